// File: sources.f
+incdir+src
+incdir+tests
src/render_pkg.sv
src/layer_if.sv
src/scan_position.sv
src/floor_texture_rom.sv
src/layer_classify.sv
src/pixel_compositor.sv
src/goose_render_top.sv
tests/tb_goose_render.sv

// File: Bender.yml
package:
  name: goose_render

sources:
  - include_dirs:
      - src
    files:
      - src/render_pkg.sv
      - src/layer_if.sv
      - src/scan_position.sv
      - src/floor_texture_rom.sv
      - src/layer_classify.sv
      - src/pixel_compositor.sv
      - src/goose_render_top.sv
  - target: test
    include_dirs:
      - src
      - tests
    files:
      - tests/tb_goose_render.sv

// File: tests/render_ref_model.svh
// Reference pixel rules of the goose renderer, included inside the testbench module
`ifndef RENDER_REF_MODEL_SVH
`define RENDER_REF_MODEL_SVH

// Sprite part at a screen position, blink flag handled by the caller
function automatic render_pkg::goose_part_e goose_part_at(input int h, input int v,
                                                          input int jump);
    int x;
    int y;
    x = h - `GOOSE_X;
    y = v - (`GOOSE_Y_BASE - jump);
    if (x < 0 || x >= `GOOSE_W || y < 0 || y >= `GOOSE_H) begin
        return render_pkg::PART_NONE;
    end
    if (y >= 20 && y <= 35 && x >= 5 && x <= 25) return render_pkg::PART_BODY;
    if (y >= 10 && y <= 19 && x >= 18 && x <= 22) return render_pkg::PART_NECK;
    if (y >= 5 && y <= 9 && x >= 18 && x <= 26) return render_pkg::PART_HEAD;
    if (y >= 7 && y <= 9 && x >= 26 && x <= 29) return render_pkg::PART_BEAK;
    if (y >= 36 && ((x >= 10 && x <= 12) || (x >= 18 && x <= 20))) begin
        return render_pkg::PART_LEGS;
    end
    return render_pkg::PART_NONE;
endfunction

function automatic render_pkg::color_t goose_color_for(input render_pkg::goose_part_e part,
                                                       input bit over);
    if (over) return make_color(3, 0, 0);
    if (part == render_pkg::PART_BODY) return make_color(2, 2, 1);
    if (part == render_pkg::PART_BEAK) return make_color(3, 2, 1);
    return make_color(0, 0, 0);
endfunction

// Texture band sits right below the floor line and scrolls with the world
function automatic bit floor_texture_bit(input int h, input int v, input int scroll);
    logic [127:0] row_bits;
    if (v < `FLOOR_Y || v >= `FLOOR_Y + `FLOOR_TEX_ROWS) return 1'b0;
    case (v - `FLOOR_Y)
        0: row_bits = `FLOOR_TEX_ROW0;
        1: row_bits = `FLOOR_TEX_ROW1;
        2: row_bits = `FLOOR_TEX_ROW2;
        default: row_bits = `FLOOR_TEX_ROW3;
    endcase
    return row_bits[(h + scroll) % 128];
endfunction

task automatic render_expected(input int h, v, scroll, jump, input bit disp, obs, blink, over,
                               output render_pkg::color_t color, output bit coll);
    render_pkg::goose_part_e part;
    int left;
    bit in_obs;
    bit on_edge;
    part = blink ? goose_part_at(h, v, jump) : render_pkg::PART_NONE;
    // Left edge wraps in 11 bits, no wrap on the right end
    left = (`OBS_X_OFFSET - scroll) & 2047;
    in_obs = obs && h >= left && h < left + `OBS_W &&
             v >= `FLOOR_Y - `OBS_H && v < `FLOOR_Y;
    on_edge = h == left || h == left + `OBS_W - 1 ||
              v == `FLOOR_Y - `OBS_H || v == `FLOOR_Y - 1;
    coll = disp && in_obs && part != render_pkg::PART_NONE;
    if (!disp) color = make_color(0, 0, 0);
    else if (part != render_pkg::PART_NONE) color = goose_color_for(part, over);
    else if (in_obs) color = on_edge ? make_color(0, 0, 0) : make_color(3, 2, 0);
    else if (floor_texture_bit(h, v, scroll)) color = make_color(3, 3, 3);
    else if (v >= `FLOOR_Y) color = make_color(1, 1, 1);
    else color = make_color(0, 3, 3);
endtask

`endif

// File: tests/tb_goose_render.sv
// Testbench for the goose renderer, drives random scan positions and checks against a model
`timescale 1ns/10ps
`default_nettype none
`include "goose_consts.svh"

module tb_goose_render;

    typedef struct packed {
        render_pkg::color_t color;
        logic               coll;
    } expect_t;

    logic        clk = 1'b0;
    logic        sys_rst = 1'b1;
    logic [9:0]  haddr;
    logic [9:0]  vaddr;
    logic [10:0] scrolladdr;
    logic [6:0]  jump_pos;
    logic        display_on;
    logic        obstacle_active;
    logic        game_start_blink;
    logic        game_over;
    logic [1:0]  r;
    logic [1:0]  g;
    logic [1:0]  b;
    logic        collision;

    int unsigned lcg_state = 32'd15753;
    int          checks = 0;
    int          errors = 0;
    int          checks_base = 0;
    int          errors_base = 0;
    int          collisions_seen = 0;
    expect_t     exp_q[$];

    function automatic render_pkg::color_t make_color(input int cr, input int cg, input int cb);
        render_pkg::color_t c;
        c.r = cr[1:0];
        c.g = cg[1:0];
        c.b = cb[1:0];
        return c;
    endfunction

    `include "render_ref_model.svh"

    goose_render_top dut (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .haddr            (haddr),
        .vaddr            (vaddr),
        .scrolladdr       (scrolladdr),
        .jump_pos         (jump_pos),
        .display_on       (display_on),
        .obstacle_active  (obstacle_active),
        .game_start_blink (game_start_blink),
        .game_over        (game_over),
        .r                (r),
        .g                (g),
        .b                (b),
        .collision        (collision)
    );

    always #5 clk = ~clk;

    // Reset over five rising edges, released on a falling edge
    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        sys_rst = 1'b0;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand()) % (hi - lo + 1);
    endfunction

    task automatic check_color(input render_pkg::color_t exp_c, input render_pkg::color_t act_c,
                               input string name);
        checks++;
        if (act_c !== exp_c) begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected (%0d,%0d,%0d) got (%0d,%0d,%0d)", $time,
                     name, exp_c.r, exp_c.g, exp_c.b, act_c.r, act_c.g, act_c.b);
        end
    endtask

    task automatic check_collision(input bit exp_b, input logic act_b, input string name);
        checks++;
        if (act_b !== exp_b) begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %0b got %0b", $time, name, exp_b, act_b);
        end
    endtask

    // One pixel per falling edge, the pixel from two edges back is checked first
    task automatic step_pixel(input int h, v, scroll, jump, input bit disp, obs, blink, over);
        expect_t            old_exp;
        expect_t            new_exp;
        render_pkg::color_t c;
        render_pkg::color_t got;
        bit                 k;
        @(negedge clk);
        if (exp_q.size() == 2) begin
            old_exp = exp_q.pop_front();
            got.r = r;
            got.g = g;
            got.b = b;
            check_color(old_exp.color, got, "rgb");
            check_collision(old_exp.coll, collision, "collision");
        end
        haddr = h[9:0];
        vaddr = v[9:0];
        scrolladdr = scroll[10:0];
        jump_pos = jump[6:0];
        display_on = disp;
        obstacle_active = obs;
        game_start_blink = blink;
        game_over = over;
        render_expected(int'(haddr), int'(vaddr), int'(scrolladdr), int'(jump_pos),
                        disp, obs, blink, over, c, k);
        new_exp.color = c;
        new_exp.coll = k;
        if (k) collisions_seen++;
        exp_q.push_back(new_exp);
    endtask

    task automatic flush_pipeline();
        repeat (2) step_pixel(rand_range(0, 1023), rand_range(0, 479), 0, 0, 1'b0, 1, 1, 0);
    endtask

    task automatic start_test();
        checks_base = checks;
        errors_base = errors;
        collisions_seen = 0;
    endtask

    task automatic finish_test(input int num, input string name);
        flush_pipeline();
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - checks_base, errors - errors_base);
    endtask

    task automatic test_background();
        int v;
        repeat (300) begin
            if (next_rand() % 2 == 0) v = rand_range(`FLOOR_Y - 4, `FLOOR_Y + 8);
            else v = rand_range(0, 479);
            step_pixel(rand_range(0, 1023), v, rand_range(0, 2047), rand_range(0, 127),
                       next_rand() % 16 != 0, 0, 0, 0);
        end
    endtask

    task automatic test_goose();
        int jump;
        int top;
        repeat (400) begin
            jump = rand_range(0, 127);
            top = `GOOSE_Y_BASE - jump;
            step_pixel(rand_range(`GOOSE_X - 5, `GOOSE_X + `GOOSE_W + 4),
                       rand_range(top - 5, top + `GOOSE_H + 4), rand_range(0, 2047), jump,
                       next_rand() % 16 != 0, 0, next_rand() % 8 != 0, next_rand() % 2);
        end
    endtask

    task automatic test_obstacle();
        int scroll;
        int h;
        repeat (400) begin
            if (next_rand() % 4 != 0) scroll = rand_range(0, 1000);
            else scroll = rand_range(0, 2047);
            h = ((`OBS_X_OFFSET - scroll) & 2047) - 4 + rand_range(0, `OBS_W + 7);
            if (h < 0 || h > 1023) h = rand_range(0, 1023);
            step_pixel(h, rand_range(`FLOOR_Y - `OBS_H - 4, `FLOOR_Y + 4), scroll,
                       rand_range(0, 127), next_rand() % 16 != 0, next_rand() % 4 != 0, 0, 0);
        end
    endtask

    // Jump and scroll pairs chosen so the obstacle sits under the goose box
    task automatic test_collision();
        int jumps[6] = '{0, 10, 25, 40, 47, 5};
        int scrolls[6] = '{840, 820, 860, 811, 879, 850};
        int top;
        for (int i = 0; i < 6; i++) begin
            top = `GOOSE_Y_BASE - jumps[i];
            repeat (100) begin
                step_pixel(rand_range(`GOOSE_X, `GOOSE_X + `GOOSE_W - 1),
                           rand_range(top, top + `GOOSE_H - 1), scrolls[i], jumps[i],
                           1, 1, 1, next_rand() % 2);
            end
        end
        if (collisions_seen == 0) begin
            errors++;
            $display("The directed overlap cases never produced an expected collision");
        end
    endtask

    task automatic test_random_mix();
        int h;
        int v;
        int scroll;
        repeat (500) begin
            h = (next_rand() % 2 == 0) ? rand_range(40, 90) : rand_range(0, 1023);
            v = (next_rand() % 2 == 0) ? rand_range(150, 260) : rand_range(0, 479);
            scroll = (next_rand() % 2 == 0) ? rand_range(800, 900) : rand_range(0, 2047);
            step_pixel(h, v, scroll, rand_range(0, 127), next_rand() % 2,
                       next_rand() % 2, next_rand() % 2, next_rand() % 2);
        end
    endtask

    initial begin
        int      wait_cycles;
        expect_t idle_exp;
        wait_cycles = 0;
        haddr = '0;
        vaddr = '0;
        scrolladdr = '0;
        jump_pos = '0;
        display_on = 1'b0;
        obstacle_active = 1'b0;
        game_start_blink = 1'b0;
        game_over = 1'b0;
        while (sys_rst !== 1'b0 && wait_cycles < 50) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (sys_rst !== 1'b0) begin
            $display("Reset was not released within %0d cycles", wait_cycles);
            $display("*** FAILED ***");
            $finish;
        end else begin
            // Pipeline holds reset state, so the first two outputs are black
            idle_exp.color = make_color(0, 0, 0);
            idle_exp.coll = 1'b0;
            exp_q.push_back(idle_exp);
            exp_q.push_back(idle_exp);
            start_test();
            step_pixel(10, 100, 0, 0, 1, 0, 0, 0);
            finish_test(1, "reset_and_latency");
            start_test();
            test_background();
            finish_test(2, "background");
            start_test();
            test_goose();
            finish_test(3, "goose");
            start_test();
            test_obstacle();
            finish_test(4, "obstacle");
            start_test();
            test_collision();
            finish_test(5, "collision");
            start_test();
            test_random_mix();
            finish_test(6, "display_blanking_mix");
            $display("Summary: %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/goose_render_top.sv
// Goose game pixel renderer top, scan position in, RGB and collision out two clocks later
`timescale 1ns/10ps
`default_nettype none

module goose_render_top (
    input  wire         clk,
    input  wire         sys_rst,
    input  wire  [9:0]  haddr,
    input  wire  [9:0]  vaddr,
    input  wire  [10:0] scrolladdr,
    input  wire  [6:0]  jump_pos,
    input  wire         display_on,
    input  wire         obstacle_active,
    input  wire         game_start_blink,
    input  wire         game_over,
    output logic [1:0]  r,
    output logic [1:0]  g,
    output logic [1:0]  b,
    output logic        collision
);

    // Stage one to stage two
    logic       pos_valid;
    logic [4:0] goose_rel_x;
    logic [5:0] goose_rel_y;
    logic       goose_in_box;
    logic [5:0] obs_rel_x;
    logic [5:0] obs_rel_y;
    logic       obs_in_box;
    logic [1:0] tex_row;
    logic [6:0] tex_addr;
    logic       tex_band;
    logic       above_floor;
    logic       game_over_q;
    logic       start_blink_q;
    logic       obstacle_active_q;

    layer_if layers ();

    scan_position u_scan_position (
        .clk               (clk),
        .sys_rst           (sys_rst),
        .haddr             (haddr),
        .vaddr             (vaddr),
        .scrolladdr        (scrolladdr),
        .jump_pos          (jump_pos),
        .display_on        (display_on),
        .obstacle_active   (obstacle_active),
        .game_start_blink  (game_start_blink),
        .game_over         (game_over),
        .pos_valid         (pos_valid),
        .goose_rel_x       (goose_rel_x),
        .goose_rel_y       (goose_rel_y),
        .goose_in_box      (goose_in_box),
        .obs_rel_x         (obs_rel_x),
        .obs_rel_y         (obs_rel_y),
        .obs_in_box        (obs_in_box),
        .tex_row           (tex_row),
        .tex_addr          (tex_addr),
        .tex_band          (tex_band),
        .above_floor       (above_floor),
        .game_over_q       (game_over_q),
        .start_blink_q     (start_blink_q),
        .obstacle_active_q (obstacle_active_q)
    );

    layer_classify u_layer_classify (
        .clk               (clk),
        .sys_rst           (sys_rst),
        .pos_valid         (pos_valid),
        .goose_rel_x       (goose_rel_x),
        .goose_rel_y       (goose_rel_y),
        .goose_in_box      (goose_in_box),
        .obs_rel_x         (obs_rel_x),
        .obs_rel_y         (obs_rel_y),
        .obs_in_box        (obs_in_box),
        .tex_row           (tex_row),
        .tex_addr          (tex_addr),
        .tex_band          (tex_band),
        .above_floor       (above_floor),
        .game_over_q       (game_over_q),
        .start_blink_q     (start_blink_q),
        .obstacle_active_q (obstacle_active_q),
        .pix               (layers.src)
    );

    pixel_compositor u_pixel_compositor (
        .pix       (layers.dst),
        .r         (r),
        .g         (g),
        .b         (b),
        .collision (collision)
    );

endmodule

`default_nettype wire

// File: src/pixel_compositor.sv
// Output stage, resolves layer priority into RGB and flags goose and obstacle overlap
`timescale 1ns/10ps
`default_nettype none

module pixel_compositor (
    layer_if.dst       pix,
    output logic [1:0] r,
    output logic [1:0] g,
    output logic [1:0] b,
    output logic       collision
);

    logic               goose_hit;
    render_pkg::color_t pixel;

    assign goose_hit = pix.goose_part != render_pkg::PART_NONE;

    // Goose over obstacle over texture over floor over sky
    always_comb begin
        if (!pix.pix_valid) begin
            pixel = render_pkg::COLOR_BLACK;
        end else if (goose_hit) begin
            pixel = pix.goose_color;
        end else if (pix.obstacle_hit) begin
            pixel = pix.obstacle_color;
        end else if (pix.tex_hit) begin
            pixel = render_pkg::COLOR_WHITE;
        end else if (pix.floor_hit) begin
            pixel = render_pkg::COLOR_FLOOR;
        end else if (pix.sky_hit) begin
            pixel = render_pkg::COLOR_SKY;
        end else begin
            pixel = render_pkg::COLOR_BLACK;
        end
    end

    assign r = pixel.r;
    assign g = pixel.g;
    assign b = pixel.b;

    // Hit flags are already cleared upstream for blanked pixels
    assign collision = goose_hit && pix.obstacle_hit;

    always_comb begin
        a_collision_valid: assert final (!collision || pix.pix_valid)
            else $error("collision raised on a blanked pixel");
    end

endmodule

`default_nettype wire

// File: src/layer_classify.sv
// Second pipeline stage, classifies goose part, obstacle and background layers per pixel
`timescale 1ns/10ps
`default_nettype none
`include "goose_consts.svh"

module layer_classify (
    input  wire        clk,
    input  wire        sys_rst,
    input  wire        pos_valid,
    input  wire  [4:0] goose_rel_x,
    input  wire  [5:0] goose_rel_y,
    input  wire        goose_in_box,
    input  wire  [5:0] obs_rel_x,
    input  wire  [5:0] obs_rel_y,
    input  wire        obs_in_box,
    input  wire  [1:0] tex_row,
    input  wire  [6:0] tex_addr,
    input  wire        tex_band,
    input  wire        above_floor,
    input  wire        game_over_q,
    input  wire        start_blink_q,
    input  wire        obstacle_active_q,
    layer_if.src       pix
);

    logic                    tex_bit;
    render_pkg::goose_part_e part_next;
    render_pkg::color_t      goose_color_next;
    logic                    obs_next;
    logic                    obs_edge;

    floor_texture_rom u_tex_rom (
        .tex_row  (tex_row),
        .tex_addr (tex_addr),
        .tex_bit  (tex_bit)
    );

    // Box rules tested in order, the first match wins
    always_comb begin
        part_next = render_pkg::PART_NONE;
        if (goose_in_box && start_blink_q) begin
            if (goose_rel_y >= 6'd20 && goose_rel_y <= 6'd35 &&
                goose_rel_x >= 5'd5 && goose_rel_x <= 5'd25) begin
                part_next = render_pkg::PART_BODY;
            end else if (goose_rel_y >= 6'd10 && goose_rel_y <= 6'd19 &&
                         goose_rel_x >= 5'd18 && goose_rel_x <= 5'd22) begin
                part_next = render_pkg::PART_NECK;
            end else if (goose_rel_y >= 6'd5 && goose_rel_y <= 6'd9 &&
                         goose_rel_x >= 5'd18 && goose_rel_x <= 5'd26) begin
                part_next = render_pkg::PART_HEAD;
            end else if (goose_rel_y >= 6'd7 && goose_rel_y <= 6'd9 &&
                         goose_rel_x >= 5'd26 && goose_rel_x <= 5'd29) begin
                part_next = render_pkg::PART_BEAK;
            end else if (goose_rel_y >= 6'd36 && goose_rel_y <= 6'd39 &&
                         ((goose_rel_x >= 5'd10 && goose_rel_x <= 5'd12) ||
                          (goose_rel_x >= 5'd18 && goose_rel_x <= 5'd20))) begin
                part_next = render_pkg::PART_LEGS;
            end
        end
    end

    // Whole goose turns red on game over
    always_comb begin
        if (game_over_q) begin
            goose_color_next = render_pkg::COLOR_RED;
        end else begin
            case (part_next)
                render_pkg::PART_BODY: goose_color_next = render_pkg::COLOR_BODY;
                render_pkg::PART_BEAK: goose_color_next = render_pkg::COLOR_BEAK;
                default:               goose_color_next = render_pkg::COLOR_BLACK;
            endcase
        end
    end

    // One-pixel black frame around a gold field
    assign obs_next = pos_valid && obstacle_active_q && obs_in_box;
    assign obs_edge = (obs_rel_x == 6'd0) || (obs_rel_x == 6'(`OBS_W - 1)) ||
                      (obs_rel_y == 6'd0) || (obs_rel_y == 6'(`OBS_H - 1));

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            pix.pix_valid    <= 1'b0;
            pix.sky_hit      <= 1'b0;
            pix.floor_hit    <= 1'b0;
            pix.tex_hit      <= 1'b0;
            pix.goose_part   <= render_pkg::PART_NONE;
            pix.obstacle_hit <= 1'b0;
        end else begin
            pix.pix_valid    <= pos_valid;
            pix.sky_hit      <= pos_valid && above_floor;
            pix.floor_hit    <= pos_valid && !above_floor;
            pix.tex_hit      <= pos_valid && tex_band && tex_bit;
            pix.goose_part   <= pos_valid ? part_next : render_pkg::PART_NONE;
            pix.obstacle_hit <= obs_next;
        end
    end

    always_ff @(posedge clk) begin
        pix.goose_color    <= goose_color_next;
        pix.obstacle_color <= obs_edge ? render_pkg::COLOR_BLACK : render_pkg::COLOR_GOLD;
    end

    // Blanked pixels never carry a goose part downstream
    a_no_part_when_blank: assert property (
        @(posedge clk) disable iff (sys_rst)
        !pix.pix_valid |-> pix.goose_part == render_pkg::PART_NONE
    ) else $error("goose part set on a blanked pixel");

endmodule

`default_nettype wire

// File: src/floor_texture_rom.sv
// Floor texture pattern lookup, four rows of 128 bits read combinationally
`timescale 1ns/10ps
`default_nettype none
`include "goose_consts.svh"

module floor_texture_rom (
    input  wire  [1:0] tex_row,
    input  wire  [6:0] tex_addr,
    output logic       tex_bit
);

    logic [127:0] row_bits;

    // Pick the row for this scan line
    always_comb begin
        case (tex_row)
            2'd0: row_bits = `FLOOR_TEX_ROW0;
            2'd1: row_bits = `FLOOR_TEX_ROW1;
            2'd2: row_bits = `FLOOR_TEX_ROW2;
            default: row_bits = `FLOOR_TEX_ROW3;
        endcase
    end

    // Pattern repeats every 128 columns
    assign tex_bit = row_bits[tex_addr];

endmodule

`default_nettype wire

// File: src/scan_position.sv
// First pipeline stage, registers the scan inputs with sprite offsets and texture address
`timescale 1ns/10ps
`default_nettype none
`include "goose_consts.svh"

module scan_position (
    input  wire         clk,
    input  wire         sys_rst,
    input  wire  [9:0]  haddr,
    input  wire  [9:0]  vaddr,
    input  wire  [10:0] scrolladdr,
    input  wire  [6:0]  jump_pos,
    input  wire         display_on,
    input  wire         obstacle_active,
    input  wire         game_start_blink,
    input  wire         game_over,
    output logic        pos_valid,
    output logic [4:0]  goose_rel_x,
    output logic [5:0]  goose_rel_y,
    output logic        goose_in_box,
    output logic [5:0]  obs_rel_x,
    output logic [5:0]  obs_rel_y,
    output logic        obs_in_box,
    output logic [1:0]  tex_row,
    output logic [6:0]  tex_addr,
    output logic        tex_band,
    output logic        above_floor,
    output logic        game_over_q,
    output logic        start_blink_q,
    output logic        obstacle_active_q
);

    logic [10:0] h_ext;
    logic [10:0] v_ext;
    logic [10:0] goose_top;
    logic [10:0] goose_dx;
    logic [10:0] goose_dy;
    logic [10:0] obs_left;
    logic [10:0] obs_dx;
    logic [10:0] obs_dy;
    logic [10:0] tex_dy;
    logic        goose_hit_box;
    logic        obs_hit_box;
    logic        in_band;

    assign h_ext = {1'b0, haddr};
    assign v_ext = {1'b0, vaddr};

    // Goose rises as jump_pos grows
    assign goose_top = 11'(`GOOSE_Y_BASE) - {4'd0, jump_pos};
    assign goose_dx  = h_ext - 11'(`GOOSE_X);
    assign goose_dy  = v_ext - goose_top;
    assign goose_hit_box = (h_ext >= 11'(`GOOSE_X)) &&
                           (h_ext < 11'(`GOOSE_X + `GOOSE_W)) &&
                           (v_ext >= goose_top) &&
                           (v_ext < goose_top + 11'(`GOOSE_H));

    // Left edge wraps mod 2048, right end is compared without wrap
    assign obs_left = 11'(`OBS_X_OFFSET) - scrolladdr;
    assign obs_dx   = h_ext - obs_left;
    assign obs_dy   = v_ext - 11'(`FLOOR_Y - `OBS_H);
    assign obs_hit_box = (h_ext >= obs_left) &&
                         ({1'b0, h_ext} < {1'b0, obs_left} + 12'(`OBS_W)) &&
                         (v_ext >= 11'(`FLOOR_Y - `OBS_H)) &&
                         (v_ext < 11'(`FLOOR_Y));

    // Textured rows just below the floor line
    assign tex_dy  = v_ext - 11'(`FLOOR_Y);
    assign in_band = (v_ext >= 11'(`FLOOR_Y)) &&
                     (v_ext < 11'(`FLOOR_Y + `FLOOR_TEX_ROWS));

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            pos_valid         <= 1'b0;
            goose_in_box      <= 1'b0;
            obs_in_box        <= 1'b0;
            tex_band          <= 1'b0;
            game_over_q       <= 1'b0;
            start_blink_q     <= 1'b0;
            obstacle_active_q <= 1'b0;
        end else begin
            pos_valid         <= display_on;
            goose_in_box      <= goose_hit_box;
            obs_in_box        <= obs_hit_box;
            tex_band          <= in_band;
            game_over_q       <= game_over;
            start_blink_q     <= game_start_blink;
            obstacle_active_q <= obstacle_active;
        end
    end

    // Offsets only matter while the matching box flag is set
    always_ff @(posedge clk) begin
        goose_rel_x <= goose_dx[4:0];
        goose_rel_y <= goose_dy[5:0];
        obs_rel_x   <= obs_dx[5:0];
        obs_rel_y   <= obs_dy[5:0];
        tex_row     <= tex_dy[1:0];
        tex_addr    <= 7'(h_ext + scrolladdr);
        above_floor <= v_ext < 11'(`FLOOR_Y);
    end

    a_goose_rel_y_in_range: assert property (
        @(posedge clk) disable iff (sys_rst)
        goose_in_box |-> goose_rel_y < 6'(`GOOSE_H)
    ) else $error("goose_rel_y out of sprite box");

endmodule

`default_nettype wire

// File: src/layer_if.sv
// Per-pixel layer hits and sprite colors passed from the classifier to the compositor
`timescale 1ns/10ps
`default_nettype none

interface layer_if;

    logic                     pix_valid;
    logic                     sky_hit;
    logic                     floor_hit;
    logic                     tex_hit;
    render_pkg::goose_part_e  goose_part;
    render_pkg::color_t       goose_color;
    logic                     obstacle_hit;
    render_pkg::color_t       obstacle_color;

    // Classifier side
    modport src (
        output pix_valid, sky_hit, floor_hit, tex_hit,
        output goose_part, goose_color, obstacle_hit, obstacle_color
    );

    // Compositor side
    modport dst (
        input pix_valid, sky_hit, floor_hit, tex_hit,
        input goose_part, goose_color, obstacle_hit, obstacle_color
    );

endinterface

`default_nettype wire

// File: src/render_pkg.sv
// Shared pixel color type, goose part encoding and palette for the goose renderer
`default_nettype none

package render_pkg;

    // 2 bits per channel
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } color_t;

    // Sprite parts in the order the classifier tests them
    typedef enum logic [2:0] {
        PART_NONE,
        PART_BODY,
        PART_NECK,
        PART_HEAD,
        PART_BEAK,
        PART_LEGS
    } goose_part_e;

    // Palette
    localparam color_t COLOR_BLACK = '{r: 2'd0, g: 2'd0, b: 2'd0};
    localparam color_t COLOR_RED   = '{r: 2'd3, g: 2'd0, b: 2'd0};
    localparam color_t COLOR_BODY  = '{r: 2'd2, g: 2'd2, b: 2'd1};
    localparam color_t COLOR_BEAK  = '{r: 2'd3, g: 2'd2, b: 2'd1};
    localparam color_t COLOR_GOLD  = '{r: 2'd3, g: 2'd2, b: 2'd0};
    localparam color_t COLOR_WHITE = '{r: 2'd3, g: 2'd3, b: 2'd3};
    localparam color_t COLOR_FLOOR = '{r: 2'd1, g: 2'd1, b: 2'd1};
    localparam color_t COLOR_SKY   = '{r: 2'd0, g: 2'd3, b: 2'd3};

endpackage

`default_nettype wire

// File: src/goose_consts.svh
// Fixed screen geometry and floor texture rows, included by the renderer RTL and its testbench
`ifndef GOOSE_CONSTS_SVH
`define GOOSE_CONSTS_SVH

// Goose sprite box, top edge moves up with jump_pos
`define GOOSE_X        50
`define GOOSE_Y_BASE   200
`define GOOSE_W        30
`define GOOSE_H        40

// Obstacle box sits on the floor line
`define OBS_W          40
`define OBS_H          48
`define OBS_X_OFFSET   890

// Floor line and textured band below it
`define FLOOR_Y        240
`define FLOOR_TEX_ROWS 4

// Texture pattern, one row per scan line of the band, bit index is the scrolled column
`define FLOOR_TEX_ROW0 128'h0000_0000_0000_0000_0000_E000_0000_0000
`define FLOOR_TEX_ROW1 128'hFFFF_FFFF_FFFF_FFFF_FFFF_3E3F_FFFF_FFFF
`define FLOOR_TEX_ROW2 128'h0000_0000_0000_0000_0000_03E0_0000_0000
`define FLOOR_TEX_ROW3 128'h0080_0200_0360_4004_0000_0408_1002_0002

`endif
